/* ctrl.f */
+incdir+include
verilog/ctrl_pkg.sv
verilog/ctrl_ifs.sv
verilog/exc_prio.sv
verilog/irq_arbiter.sv
verilog/ctrl_fsm.sv
verilog/ctrl_top.sv
verification/tb_clk_gen.sv
verification/ctrl_chk.sv
verification/ctrl_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run ctrl_tb and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f ctrl.f --top-module ctrl_tb -Mdir obj_dir
	./obj_dir/Vctrl_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

/* verification/ctrl_golden.txt */
// id dec misc irqs instr pc lsu_addr wait exp_flags exp_cause exp_mtval, all hex
// flags={busy,ivclr,idrdy,run,req,pcset,saveif,saveid,mret,savecause,flush,nmi,pcmux[1:0],excpc}
1 00 0004 00000 00000000 00000000 00000000 0 7200 00 00000000
1 00 0004 00000 00000000 00000000 00000000 0 7600 00 00000000
1 00 0004 00000 00000000 00000000 00000000 0 7400 00 00000000
1 00 0004 00000 00000000 00000000 00000000 1 7c02 00 00000000
2 00 2084 00000 00000013 00000080 00000000 0 7e02 00 00000000
2 00 2c44 00000 00000013 00000100 00000000 0 4c02 00 00000000
2 00 2c44 00000 00000013 00000100 00000000 3 66b5 01 00000102
3 20 2004 00000 deadbeef 00000104 00000000 0 4c02 00 00000000
3 20 2004 00000 deadbeef 00000104 00000000 0 66b5 02 deadbeef
3 32 3004 00000 12344321 00000108 00000000 0 4c02 00 00000000
3 32 3004 00000 12344321 00000108 00000000 0 66b5 02 00004321
3 10 2000 00000 00000073 0000010c 00000000 0 4c02 00 00000000
3 10 2000 00000 00000073 0000010c 00000000 0 66b5 08 00000000
3 10 2004 00000 00000073 00000110 00000000 0 4c02 00 00000000
3 10 2004 00000 00000073 00000110 00000000 0 66b5 0b 00000000
3 08 2000 00000 30200073 00000114 00000000 0 4c02 00 00000000
3 08 2000 00000 30200073 00000114 00000000 0 66b5 02 30200073
3 04 2002 00000 10500073 00000118 00000000 0 4c02 00 00000000
3 04 2002 00000 10500073 00000118 00000000 0 66b5 02 10500073
3 02 2004 00000 00100073 0000011c 00000000 0 4c02 00 00000000
3 02 2004 00000 00100073 0000011c 00000000 0 66b5 03 00000000
3 00 0304 00000 00000000 00000120 20000010 0 4c02 00 00000000
3 00 0304 00000 00000000 00000120 20000010 0 66b5 07 20000010
3 30 2804 00000 00000000 00000200 00000000 0 4c02 00 00000000
3 30 2804 00000 00000000 00000200 00000000 0 66b5 01 00000200
3 00 0004 00000 00000000 00000000 00000000 0 7c02 00 00000000
4 00 0034 38208 00000000 00000000 00000000 0 6c02 00 00000000
4 00 0034 38208 00000000 00000000 00000000 3 7724 39 00000000
4 00 0034 38000 00000000 00000000 00000000 0 6c02 00 00000000
4 00 0034 38000 00000000 00000000 00000000 3 7724 2b 00000000
4 00 0034 30000 00000000 00000000 00000000 0 6c02 00 00000000
4 00 0034 30000 00000000 00000000 00000000 3 7724 23 00000000
4 00 0034 10000 00000000 00000000 00000000 0 6c02 00 00000000
4 00 0034 10000 00000000 00000000 00000000 3 7724 27 00000000
4 00 003c 08000 00000000 00000000 00000000 0 6c02 00 00000000
4 00 003c 08000 00000000 00000000 00000000 3 7724 3f 00000000
4 00 0034 08000 00000000 00000000 00000000 0 7c0a 00 00000000
4 08 2034 08000 30200073 00000300 00000000 0 4c0a 00 00000000
4 08 2034 08000 30200073 00000300 00000000 0 665e 00 00000000
4 00 0034 08000 00000000 00000000 00000000 0 6c02 00 00000000
4 00 0034 08000 00000000 00000000 00000000 3 7724 2b 00000000
5 04 2004 00000 10500073 00000400 00000000 0 4c02 00 00000000
5 04 2004 00000 10500073 00000400 00000000 0 6410 00 00000000
5 00 0004 00000 00000000 00000000 00000000 2 2010 00 00000000
5 00 0004 00000 00000000 00000000 00000000 0 2010 00 00000000
5 00 0014 00000 00000000 00000000 00000000 0 6010 00 00000000
5 00 0034 10000 00000000 00000000 00000000 0 6400 00 00000000
5 00 0034 10000 00000000 00000000 00000000 3 7724 27 00000000
6 00 0035 10000 00000000 00000000 00000000 0 4c02 00 00000000
6 00 0035 10000 00000000 00000000 00000000 0 4c02 00 00000000
6 00 0034 10000 00000000 00000000 00000000 0 6c02 00 00000000
6 00 0034 10000 00000000 00000000 00000000 3 7724 27 00000000
6 00 0004 00000 00000000 00000000 00000000 0 7c02 00 00000000
7 01 2034 20000 00000000 00000500 00000000 0 4c02 00 00000000
7 01 2034 20000 00000000 00000500 00000000 0 6410 00 00000000
7 00 0034 20000 00000000 00000000 00000000 3 7724 23 00000000
7 00 0004 00000 00000000 00000000 00000000 0 7c02 00 00000000

/* verification/ctrl_tb.sv */
// vector testbench for ctrl_top with vectors and expected values from the golden file
// run from the project root so the golden file path resolves

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_tb import ctrl_pkg::*; ();

  localparam int MAX_VEC = 128;

  logic clk, rst_n;
  logic illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i, csr_pipe_flush_i;
  logic instr_valid_i, instr_is_compressed_i, instr_fetch_err_i, instr_fetch_err_plus2_i;
  logic [`CTRL_XLEN-1:0] instr_i, pc_id_i, lsu_addr_last_i;
  logic [15:0] instr_compressed_i;
  logic load_err_i, store_err_i, branch_set_i, jump_set_i;
  logic csr_mstatus_mie_i, irq_pending_i, irq_nm_i, csr_mstatus_tw_i, stall_id_i;
  irqs_t irqs_i;
  priv_lvl_e priv_mode_i;
  logic ctrl_busy_o, instr_valid_clear_o, id_in_ready_o, controller_run_o, instr_req_o;
  logic pc_set_o, csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o, csr_save_cause_o;
  logic flush_id_o, nmi_mode_o;
  pc_sel_e pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  exc_cause_e exc_cause_o;
  logic [`CTRL_XLEN-1:0] csr_mtval_o;

  // golden columns with one entry per vector
  logic [31:0] v_id [MAX_VEC];
  logic [31:0] v_dec [MAX_VEC];
  logic [31:0] v_misc [MAX_VEC];
  logic [31:0] v_irqs [MAX_VEC];
  logic [31:0] v_instr [MAX_VEC];
  logic [31:0] v_pc [MAX_VEC];
  logic [31:0] v_addr [MAX_VEC];
  logic [31:0] v_wait [MAX_VEC];
  logic [31:0] v_exp [MAX_VEC];
  logic [31:0] v_cause [MAX_VEC];
  logic [31:0] v_mtval [MAX_VEC];

  int n_vec, err_cnt, chk_cnt, test_cnt, test_fail, test_err, cur_vec;
  bit loaded;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  ctrl_top DUT (.clk_i(clk), .rst_ni(rst_n), .*);

  // compare one value and print on mismatch
  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      test_err++;
      $display("[ERROR] %0t: test %0d vector %0d %s got %h expected %h",
               $time, v_id[cur_vec], cur_vec, what, got, exp);
    end
  endtask

  // misc = {vld,cmp,ferr,p2,lerr,serr,br,jmp,mie,pend,nmi,privm,tw,stall}
  task automatic drive_vector(input int i);
    illegal_insn_i          = v_dec[i][5];
    ecall_insn_i            = v_dec[i][4];
    mret_insn_i             = v_dec[i][3];
    wfi_insn_i              = v_dec[i][2];
    ebrk_insn_i             = v_dec[i][1];
    csr_pipe_flush_i        = v_dec[i][0];
    instr_valid_i           = v_misc[i][13];
    instr_is_compressed_i   = v_misc[i][12];
    instr_fetch_err_i       = v_misc[i][11];
    instr_fetch_err_plus2_i = v_misc[i][10];
    load_err_i              = v_misc[i][9];
    store_err_i             = v_misc[i][8];
    branch_set_i            = v_misc[i][7];
    jump_set_i              = v_misc[i][6];
    csr_mstatus_mie_i       = v_misc[i][5];
    irq_pending_i           = v_misc[i][4];
    irq_nm_i                = v_misc[i][3];
    priv_mode_i             = v_misc[i][2] ? PRIV_LVL_M : PRIV_LVL_U;
    csr_mstatus_tw_i        = v_misc[i][1];
    stall_id_i              = v_misc[i][0];
    irqs_i                  = irqs_t'(v_irqs[i][17:0]);
    instr_i                 = v_instr[i];
    instr_compressed_i      = v_instr[i][15:0];
    pc_id_i                 = v_pc[i];
    lsu_addr_last_i         = v_addr[i];
  endtask

  // 0 none, 1 controller running, 2 core idle, 3 PC set
  function automatic bit wait_done(input logic [31:0] code);
    case (code)
      32'd1:   return controller_run_o;
      32'd2:   return !ctrl_busy_o;
      32'd3:   return pc_set_o;
      default: return 1'b1;
    endcase
  endfunction

  task automatic check_vector(input int i);
    logic [14:0] flags;
    flags = {ctrl_busy_o, instr_valid_clear_o, id_in_ready_o, controller_run_o, instr_req_o,
             pc_set_o, csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o, csr_save_cause_o,
             flush_id_o, nmi_mode_o, pc_mux_o, exc_pc_mux_o};
    cur_vec = i;
    check_value("flags", 32'(flags), v_exp[i]);
    check_value("cause", 32'(exc_cause_o), v_cause[i]);
    check_value("mtval", csr_mtval_o, v_mtval[i]);
  endtask

  initial begin
    int fd, cnt;
    string line;
    logic [31:0] f [11];
    n_vec = 0;
    fd = $fopen("verification/ctrl_golden.txt", "r");
    if (fd != 0) begin
      // last slot holds the idle inputs
      while (!$feof(fd) && n_vec < MAX_VEC - 1) begin
        line = "";
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        // comment and blank lines give fewer fields
        if (cnt == 11) begin
          v_id[n_vec]    = f[0];
          v_dec[n_vec]   = f[1];
          v_misc[n_vec]  = f[2];
          v_irqs[n_vec]  = f[3];
          v_instr[n_vec] = f[4];
          v_pc[n_vec]    = f[5];
          v_addr[n_vec]  = f[6];
          v_wait[n_vec]  = f[7];
          v_exp[n_vec]   = f[8];
          v_cause[n_vec] = f[9];
          v_mtval[n_vec] = f[10];
          n_vec++;
        end
      end
      $fclose(fd);
    end
    // idle inputs until the first vector
    v_misc[MAX_VEC-1] = 32'h4;
    v_dec[MAX_VEC-1] = '0;
    v_irqs[MAX_VEC-1] = '0;
    v_instr[MAX_VEC-1] = '0;
    v_pc[MAX_VEC-1] = '0;
    v_addr[MAX_VEC-1] = '0;
    drive_vector(MAX_VEC-1);
    loaded = 1'b1;
    @(posedge rst_n);
    for (int i = 0; i < n_vec; i++) begin
      @(posedge clk);
      #1;
      drive_vector(i);
      // sample late in the cycle once outputs settle
      #6;
      while (!wait_done(v_wait[i])) begin
        @(posedge clk);
        #7;
      end
      check_vector(i);
      if (i == n_vec - 1 || v_id[i+1] != v_id[i]) begin
        test_cnt++;
        if (test_err != 0) begin
          test_fail++;
        end
        $display("test %0d: %s", v_id[i], (test_err == 0) ? "pass" : "FAIL");
        test_err = 0;
      end
    end
    if (n_vec == 0) begin
      $display("no vectors read from the golden file");
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, test_fail, chk_cnt, err_cnt, DUT.u_ctrl_fsm.u_ctrl_chk.fail_cnt);
    if (n_vec != 0 && err_cnt == 0 && DUT.u_ctrl_fsm.u_ctrl_chk.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog allows 40 cycles per vector plus a reset margin
  initial begin
    wait (loaded);
    repeat (n_vec * 40 + 200) @(posedge clk);
    $display("timeout: vectors did not finish within %0d cycles", n_vec * 40 + 200);
    $display("Something failed");
    $finish;
  end

endmodule

/* verification/ctrl_chk.sv */
// concurrent checks on the controller FSM, bound into ctrl_fsm
// fail_cnt is read by the testbench at the end of the run

`timescale 1ns/1ps

module ctrl_chk import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ctrl_state_e state_q,
  input  logic        pc_set_o,
  input  pc_sel_e     pc_mux_o,
  input  logic        nmi_mode_o,
  input  logic        ctrl_busy_o
);

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // trap vector only from the two trap states
  exc_vector_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_o && pc_mux_o == PC_EXC) |-> (state_q inside {FLUSH, IRQ_TAKEN}))
    else begin
      $error("exception PC set outside FLUSH or IRQ_TAKEN");
      fail_cnt++;
    end

  // nmi mode entered only when taking the NMI
  nmi_mode_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(nmi_mode_o) |-> ($past(state_q) == IRQ_TAKEN))
    else begin
      $error("nmi mode rose outside IRQ_TAKEN");
      fail_cnt++;
    end

  // core reports idle while waiting for sleep
  idle_in_wait_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WAIT_SLEEP) |-> !ctrl_busy_o)
    else begin
      $error("ctrl_busy_o high in WAIT_SLEEP");
      fail_cnt++;
    end

endmodule

bind ctrl_fsm ctrl_chk u_ctrl_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .state_q     (state_q),
  .pc_set_o    (pc_set_o),
  .pc_mux_o    (pc_mux_o),
  .nmi_mode_o  (nmi_mode_o),
  .ctrl_busy_o (ctrl_busy_o)
);

/* verification/tb_clk_gen.sv */
// testbench clock and reset, 8 ns period
// reset released 1 ns after the 16th rising edge

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

/* verilog/ctrl_top.sv */
// decode-stage controller top, plain ports
// no writeback stage, no debug mode, no branch prediction

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_top import ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // decoder
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  wfi_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  csr_pipe_flush_i,
  // IF-ID register
  input  logic                  instr_valid_i,
  input  logic [`CTRL_XLEN-1:0] instr_i,
  input  logic [15:0]           instr_compressed_i,
  input  logic                  instr_is_compressed_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  instr_fetch_err_plus2_i,
  input  logic [`CTRL_XLEN-1:0] pc_id_i,
  // LSU
  input  logic [`CTRL_XLEN-1:0] lsu_addr_last_i,
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  // branch unit
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  // interrupts
  input  logic                  csr_mstatus_mie_i,
  input  logic                  irq_pending_i,
  input  irqs_t                 irqs_i,
  input  logic                  irq_nm_i,
  // privilege
  input  priv_lvl_e             priv_mode_i,
  input  logic                  csr_mstatus_tw_i,
  input  logic                  stall_id_i,
  // to IF stage and CSRs
  output logic                  ctrl_busy_o,
  output logic                  instr_valid_clear_o,
  output logic                  id_in_ready_o,
  output logic                  controller_run_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,
  output logic                  flush_id_o,
  output logic                  nmi_mode_o,
  output pc_sel_e               pc_mux_o,
  output exc_pc_sel_e           exc_pc_mux_o,
  output exc_cause_e            exc_cause_o,
  output logic [`CTRL_XLEN-1:0] csr_mtval_o
);

  exc_if exc ();
  irq_if irq ();

  exc_prio u_exc_prio (
    .clk_i, .rst_ni,
    .illegal_insn_i, .ecall_insn_i, .mret_insn_i, .wfi_insn_i, .ebrk_insn_i,
    .csr_pipe_flush_i, .instr_valid_i, .instr_i, .instr_compressed_i,
    .instr_is_compressed_i, .instr_fetch_err_i, .instr_fetch_err_plus2_i, .pc_id_i,
    .lsu_addr_last_i, .load_err_i, .store_err_i, .priv_mode_i, .csr_mstatus_tw_i,
    .exc (exc.src)
  );

  irq_arbiter u_irq_arbiter (
    .csr_mstatus_mie_i, .irq_pending_i, .irqs_i, .irq_nm_i,
    .irq (irq.src)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .instr_valid_i, .branch_set_i, .jump_set_i, .instr_fetch_err_i,
    .irq_nm_i, .irq_pending_i, .stall_id_i,
    .exc (exc.dst),
    .irq (irq.dst),
    .ctrl_busy_o, .instr_valid_clear_o, .id_in_ready_o, .controller_run_o, .instr_req_o,
    .pc_set_o, .csr_save_if_o, .csr_save_id_o, .csr_restore_mret_id_o, .csr_save_cause_o,
    .flush_id_o, .nmi_mode_o, .pc_mux_o, .exc_pc_mux_o, .exc_cause_o, .csr_mtval_o
  );

endmodule

/* verilog/ctrl_fsm.sv */
// decode-stage controller FSM: PC redirects, CSR strobes, NMI mode and IF-ID stall control
// first cycle after reset release only arms the boot sequence, so reset outputs stay low

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_fsm import ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_pending_i,
  input  logic                  stall_id_i,
  exc_if.dst                    exc,
  irq_if.dst                    irq,
  output logic                  ctrl_busy_o,
  output logic                  instr_valid_clear_o,
  output logic                  id_in_ready_o,
  output logic                  controller_run_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,
  output logic                  flush_id_o,
  output logic                  nmi_mode_o,
  output pc_sel_e               pc_mux_o,
  output exc_pc_sel_e           exc_pc_mux_o,
  output exc_cause_e            exc_cause_o,
  output logic [`CTRL_XLEN-1:0] csr_mtval_o
);

  ctrl_state_e state_q, state_d;
  logic        nmi_mode_q, nmi_mode_d;
  logic        started_q;
  logic        halt_if, retain_id, flush_id;
  logic        fetch_err;

  // only a fetch error can cancel a branch redirect
  assign fetch_err = instr_fetch_err_i & instr_valid_i;

  always_comb begin
    state_d               = state_q;
    nmi_mode_d            = nmi_mode_q;
    instr_req_o           = 1'b1;
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    exc_cause_o           = exc_cause_e'('0);
    csr_mtval_o           = '0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_save_cause_o      = 1'b0;
    ctrl_busy_o           = 1'b1;
    controller_run_o      = 1'b0;
    halt_if               = 1'b0;
    retain_id             = 1'b0;
    flush_id              = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        // hold off until the first edge after release
        if (started_q) begin
          pc_set_o = 1'b1;
          state_d  = BOOT_SET;
        end
      end
      BOOT_SET: begin
        // load boot address into the fetch PC
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // any pending line wakes, enabled or not
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (irq.take_irq) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end
      DECODE: begin
        controller_run_o = 1'b1;
        // mux set early, only matters with pc_set_o
        pc_mux_o         = PC_JUMP;
        if (exc.special_req) begin
          // keep the instruction in ID for FLUSH to inspect
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if (!fetch_err && (branch_set_i || jump_set_i)) begin
          pc_set_o = 1'b1;
        end
        // interrupts wait for the current instruction to finish
        if (irq.take_irq) begin
          halt_if = 1'b1;
          if (!stall_id_i && !exc.special_req) begin
            state_d = IRQ_TAKEN;
          end
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (irq.take_irq) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq.irq_cause;
          if (irq.irq_is_nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc.exc_pending) begin
          // trap: mepc from ID, cause and mtval from exc_prio
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc.exc_cause;
          csr_mtval_o      = exc.exc_mtval;
        end else if (exc.mret) begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
          nmi_mode_d            = 1'b0;
        end else if (exc.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (exc.csr_flush && irq.take_irq) begin
          // CSR write may have just enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retained instruction keeps its valid bit unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;

  assign exc.in_flush = (state_q == FLUSH);
  assign irq.nmi_mode = nmi_mode_q;
  assign nmi_mode_o   = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
      started_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
      started_q  <= 1'b1;
    end
  end

endmodule

/* verilog/irq_arbiter.sv */
// interrupt take decision and cause, purely combinational
// nested NMIs are not supported: nothing is taken while in NMI mode

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module irq_arbiter import ctrl_pkg::*; (
  input  logic  csr_mstatus_mie_i,
  input  logic  irq_pending_i,
  input  irqs_t irqs_i,
  input  logic  irq_nm_i,
  irq_if.src    irq
);

  logic [`CTRL_FAST_ID_W-1:0] fast_id;
  logic                       fast_any;

  // NMI ignores mstatus.MIE, all others need it
  assign irq.take_irq   = ~irq.nmi_mode & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));
  assign irq.irq_is_nmi = irq_nm_i;

  // highest set fast line wins
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = `CTRL_FAST_ID_W'(i);
      end
    end
  end

  assign fast_any = |irqs_i.irq_fast;

  //////////////////////////////////////////////////////////////////////
  // cause priority: NMI, fast, external, software, timer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (irq_nm_i) begin
      irq.irq_cause = EXC_CAUSE_IRQ_NM;
    end else if (fast_any) begin
      // interrupt flag plus 16 on top of the line index
      irq.irq_cause = exc_cause_e'({2'b11, fast_id});
    end else if (irqs_i.irq_external) begin
      irq.irq_cause = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq.irq_cause = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      // timer, the only line left once take_irq is high
      irq.irq_cause = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

/* verilog/exc_prio.sv */
// synchronous exception detection and priority for the instruction in ID
// decoder flags are not valid-qualified on input; LSU errors arrive without instr_valid_i

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module exc_prio import ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // decoder
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  wfi_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  csr_pipe_flush_i,
  // IF-ID register
  input  logic                  instr_valid_i,
  input  logic [`CTRL_XLEN-1:0] instr_i,
  input  logic [15:0]           instr_compressed_i,
  input  logic                  instr_is_compressed_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  instr_fetch_err_plus2_i,
  input  logic [`CTRL_XLEN-1:0] pc_id_i,
  // LSU
  input  logic [`CTRL_XLEN-1:0] lsu_addr_last_i,
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  // privilege
  input  priv_lvl_e             priv_mode_i,
  input  logic                  csr_mstatus_tw_i,
  exc_if.src                    exc
);

  logic ecall_insn, mret_insn, wfi_insn, ebrk_insn, csr_flush, fetch_err;
  logic illegal_umode;
  logic illegal_insn_d, illegal_insn_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;

  // decoder flags only count with a valid instruction
  assign ecall_insn = ecall_insn_i      & instr_valid_i;
  assign mret_insn  = mret_insn_i       & instr_valid_i;
  assign wfi_insn   = wfi_insn_i        & instr_valid_i;
  assign ebrk_insn  = ebrk_insn_i       & instr_valid_i;
  assign csr_flush  = csr_pipe_flush_i  & instr_valid_i;
  assign fetch_err  = instr_fetch_err_i & instr_valid_i;

  // MRET, and WFI under mstatus.TW, trap outside M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (mret_insn | (csr_mstatus_tw_i & wfi_insn));

  // illegal_insn_i has no valid qualifier of its own
  assign illegal_insn_d = ((illegal_insn_i & instr_valid_i) | illegal_umode) & ~exc.in_flush;
  assign exc_req_d      = (ecall_insn | ebrk_insn | illegal_insn_d | fetch_err) & ~exc.in_flush;

  // requests are seen in DECODE and acted on in FLUSH one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_insn_q <= 1'b0;
      exc_req_q      <= 1'b0;
      load_err_q     <= 1'b0;
      store_err_q    <= 1'b0;
    end else begin
      illegal_insn_q <= illegal_insn_d;
      exc_req_q      <= exc_req_d;
      load_err_q     <= load_err_i  & ~exc.in_flush;
      store_err_q    <= store_err_i & ~exc.in_flush;
    end
  end

  assign exc.exc_pending = exc_req_q | load_err_q | store_err_q;
  assign exc.special_req = mret_insn | wfi_insn | csr_flush | exc_req_d | load_err_i | store_err_i;
  assign exc.mret        = mret_insn;
  assign exc.wfi         = wfi_insn;
  assign exc.csr_flush   = csr_flush;

  // one winner, ordered as in the privileged spec
  always_comb begin
    exc.exc_cause = exc_cause_e'('0);
    exc.exc_mtval = '0;
    if (fetch_err) begin
      exc.exc_cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault in the upper half of a word-straddling instruction
      exc.exc_mtval = instr_fetch_err_plus2_i ? pc_id_i + xlen_t'(2) : pc_id_i;
    end else if (illegal_insn_q) begin
      exc.exc_cause = EXC_CAUSE_ILLEGAL_INSN;
      exc.exc_mtval = instr_is_compressed_i ? xlen_t'(instr_compressed_i) : instr_i;
    end else if (ecall_insn) begin
      exc.exc_cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE
                                                  : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      exc.exc_cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc.exc_cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      exc.exc_mtval = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc.exc_cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      exc.exc_mtval = lsu_addr_last_i;
    end
  end

endmodule

/* verilog/ctrl_ifs.sv */
// links from the exception and interrupt blocks into the controller FSM
// plain strobes and levels, no handshake

`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// exception requests, exc_prio -> ctrl_fsm
//////////////////////////////////////////////////////////////////////

interface exc_if import ctrl_pkg::*; ();
  // registered request, any source
  logic       exc_pending;
  // combinational, anything needing FLUSH this cycle
  logic       special_req;
  // valid-qualified special instructions
  logic       mret;
  logic       wfi;
  logic       csr_flush;
  // cause and mtval of the winning exception
  exc_cause_e exc_cause;
  xlen_t      exc_mtval;
  // FSM is in FLUSH, clears the registered requests
  logic       in_flush;

  modport src (output exc_pending, special_req, mret, wfi, csr_flush, exc_cause, exc_mtval,
               input in_flush);
  modport dst (input exc_pending, special_req, mret, wfi, csr_flush, exc_cause, exc_mtval,
               output in_flush);
endinterface

//////////////////////////////////////////////////////////////////////
// interrupt decision, irq_arbiter -> ctrl_fsm
//////////////////////////////////////////////////////////////////////

interface irq_if import ctrl_pkg::*; ();
  logic       take_irq;
  exc_cause_e irq_cause;
  logic       irq_is_nmi;
  // core is running the NMI handler
  logic       nmi_mode;

  modport src (output take_irq, irq_cause, irq_is_nmi, input nmi_mode);
  modport dst (input take_irq, irq_cause, irq_is_nmi, output nmi_mode);
endinterface

/* verilog/ctrl_pkg.sv */
// types shared by the decode-stage controller
// needs include/ on the include path

`include "ctrl_defs.svh"

package ctrl_pkg;

  // one data or address word
  typedef logic [`CTRL_XLEN-1:0] xlen_t;

  // fetch address selector for the IF stage
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // vector selector, only looked at with PC_EXC
  typedef enum logic {
    EXC_PC_IRQ = 1'b0,
    EXC_PC_EXC = 1'b1
  } exc_pc_sel_e;

  // mcause codes; fast line n is 48 + n and is built by a cast
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'd35,
    EXC_CAUSE_IRQ_TIMER_M        = 6'd39,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'd43,
    EXC_CAUSE_IRQ_NM             = 6'd63
  } exc_cause_e;

  // only U and M modes exist
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // request lines, already qualified with mie
  typedef struct packed {
    logic                          irq_software;
    logic                          irq_timer;
    logic                          irq_external;
    logic [`CTRL_NUM_FAST_IRQ-1:0] irq_fast;
  } irqs_t;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_state_e;

endpackage

/* include/ctrl_defs.svh */
// widths and counts shared by the controller package and RTL
// CTRL_FAST_ID_W must cover CTRL_NUM_FAST_IRQ lines, and 2 + CTRL_FAST_ID_W == CTRL_CAUSE_W
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// data and address width
`define CTRL_XLEN 32

// number of fast interrupt lines
`define CTRL_NUM_FAST_IRQ 15

// width of a fast interrupt index
`define CTRL_FAST_ID_W 4

// exception cause code width, top bit marks an interrupt
`define CTRL_CAUSE_W 6

`endif
